// File: design/tinker_pkg.sv
//----------------------------------------------------------
// Shared definitions for the Tinker pipelined core.
// Opcodes, widths, reset PC and the pipeline register structs.
// Every file refers to these by tinker_pkg:: scoped names.
//----------------------------------------------------------
package tinker_pkg;

    localparam int xlen  = 64;
    localparam int imm_w = 12;

    typedef logic [xlen-1:0] word_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_idx_t;

    localparam word_t reset_pc = 64'h2000;  // First fetch address

    typedef enum logic [4:0] {
        op_and   = 5'h00, op_or     = 5'h01, op_xor   = 5'h02, op_not    = 5'h03,
        op_shftr = 5'h04, op_shftri = 5'h05, op_shftl = 5'h06, op_shftli = 5'h07,
        op_br    = 5'h08, op_brr    = 5'h09, op_brrl  = 5'h0a, op_brnz   = 5'h0b,
        op_brgt  = 5'h0e, op_halt   = 5'h0f,
        op_load  = 5'h10, op_movr   = 5'h11, op_movl  = 5'h12, op_store  = 5'h13,
        op_add   = 5'h18, op_addi   = 5'h19, op_sub   = 5'h1a, op_subi   = 5'h1b
    } opcode_t;

    // Operand source picked by the forwarding logic
    typedef enum logic [1:0] {
        fwd_rf  = 2'd0,
        fwd_exm = 2'd1,
        fwd_wb  = 2'd2
    } fwd_sel_t;

    typedef struct packed {
        opcode_t op;
        logic    use_imm;    // Literal replaces rt
        logic    reg_write;
        logic    is_load;
        logic    is_store;
        logic    is_branch;
        logic    is_halt;
    } ctrl_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        ctrl_t    ctrl;
        reg_idx_t rd;
        reg_idx_t rs;
        reg_idx_t rt;
        word_t    imm;
        word_t    rd_val;
        word_t    rs_val;
        word_t    rt_val;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        ctrl_t    ctrl;
        reg_idx_t rd;
        word_t    result;
        word_t    addr;
        word_t    store_data;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    wb_data;
        logic     reg_write;
        logic     halt;
    } mem_wb_t;

    typedef struct packed {
        logic  wr_valid;
        word_t wr_addr;
        word_t wr_data;
        word_t rd_addr;   // Always driven, read is combinational
    } dmem_req_t;

endpackage

// File: design/pipe_reg.sv
//----------------------------------------------------------
// Generic pipeline register for any packed payload.
// Hold keeps the value, flush and reset clear it to zero.
//----------------------------------------------------------
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     hold,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;        // Bubble, valid bit drops too
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

// File: design/fetch_stage.sv
//----------------------------------------------------------
// Program counter and the fetch/decode register.
// Redirect wins over stall, a halt in execute freezes fetch.
//----------------------------------------------------------
`timescale 1ns/1ps

module fetch_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              redirect,
    input  tinker_pkg::word_t target,
    input  logic              stall,
    input  logic              freeze,
    input  tinker_pkg::inst_t imem_data,
    output tinker_pkg::word_t imem_addr,
    output tinker_pkg::word_t ifid_pc,
    output tinker_pkg::inst_t ifid_inst,
    output logic              ifid_valid
);

    tinker_pkg::word_t pc;
    logic              frozen;   // Sticky until reset
    logic              halted;
    logic              advance;

    assign imem_addr = pc;
    assign halted    = freeze | frozen;
    assign advance   = !redirect && !halted && !stall;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc         <= tinker_pkg::reset_pc;
            ifid_valid <= 1'b0;
            frozen     <= 1'b0;
        end else begin
            if (freeze) begin
                frozen <= 1'b1;
            end
            if (redirect) begin
                pc         <= target;
                ifid_valid <= 1'b0;     // Flush wrong-path fetch
            end else if (halted) begin
                ifid_valid <= 1'b0;
            end else if (!stall) begin
                pc         <= pc + 64'd4;
                ifid_valid <= 1'b1;
            end
        end
    end

    // Payload only moves with the valid bit
    always_ff @(posedge clk) begin
        if (advance) begin
            ifid_pc   <= pc;
            ifid_inst <= imem_data;
        end
    end

endmodule

// File: design/instr_decoder.sv
//----------------------------------------------------------
// Instruction field split and control word table.
// Unknown opcodes decode to an all-zero control word (no-op).
//----------------------------------------------------------
`timescale 1ns/1ps

module instr_decoder (
    input  tinker_pkg::inst_t    inst,
    output tinker_pkg::ctrl_t    ctrl,
    output tinker_pkg::reg_idx_t rd,
    output tinker_pkg::reg_idx_t rs,
    output tinker_pkg::reg_idx_t rt,
    output tinker_pkg::word_t    imm
);

    assign rd  = inst[26:22];
    assign rs  = inst[21:17];
    assign rt  = inst[16:12];
    assign imm = {{(tinker_pkg::xlen - tinker_pkg::imm_w){inst[tinker_pkg::imm_w-1]}},
                  inst[tinker_pkg::imm_w-1:0]};

    always_comb begin
        ctrl    = '0;
        ctrl.op = tinker_pkg::opcode_t'(inst[31:27]);
        case (ctrl.op)
            tinker_pkg::op_and, tinker_pkg::op_or, tinker_pkg::op_xor, tinker_pkg::op_not,
            tinker_pkg::op_shftr, tinker_pkg::op_shftl, tinker_pkg::op_add,
            tinker_pkg::op_sub, tinker_pkg::op_movr: begin
                ctrl.reg_write = 1'b1;
            end
            tinker_pkg::op_shftri, tinker_pkg::op_shftli, tinker_pkg::op_addi,
            tinker_pkg::op_subi, tinker_pkg::op_movl: begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            tinker_pkg::op_load: begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.is_load   = 1'b1;
            end
            tinker_pkg::op_store: begin
                ctrl.use_imm  = 1'b1;
                ctrl.is_store = 1'b1;
            end
            tinker_pkg::op_brrl: begin
                ctrl.use_imm   = 1'b1;
                ctrl.is_branch = 1'b1;
            end
            tinker_pkg::op_br, tinker_pkg::op_brr, tinker_pkg::op_brnz,
            tinker_pkg::op_brgt: ctrl.is_branch = 1'b1;
            tinker_pkg::op_halt: ctrl.is_halt = 1'b1;
            default: ;
        endcase
    end

endmodule

// File: design/register_file.sv
//----------------------------------------------------------
// 32 x 64-bit register file, three read ports, one write.
// Reading the register being written returns the new value.
//----------------------------------------------------------
`timescale 1ns/1ps

module register_file (
    input  logic                 clk,
    input  logic                 reset,
    input  tinker_pkg::reg_idx_t rd_idx,
    input  tinker_pkg::reg_idx_t rs_idx,
    input  tinker_pkg::reg_idx_t rt_idx,
    input  logic                 wr_en,
    input  tinker_pkg::reg_idx_t wr_idx,
    input  tinker_pkg::word_t    wr_data,
    output tinker_pkg::word_t    rd_val,
    output tinker_pkg::word_t    rs_val,
    output tinker_pkg::word_t    rt_val
);

    tinker_pkg::word_t regs [32];

    function automatic tinker_pkg::word_t read_port(tinker_pkg::reg_idx_t idx);
        return (wr_en && wr_idx == idx) ? wr_data : regs[idx];   // Write-first bypass
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rd_val = read_port(rd_idx);
    assign rs_val = read_port(rs_idx);
    assign rt_val = read_port(rt_idx);

endmodule

// File: design/hazard_unit.sv
//----------------------------------------------------------
// Forwarding select for rs, rt and rd in execute, and the
// load-use stall for the instruction sitting in decode.
//----------------------------------------------------------
`timescale 1ns/1ps

module hazard_unit (
    input  tinker_pkg::id_ex_t   id_ex,
    input  tinker_pkg::ex_mem_t  ex_mem,
    input  tinker_pkg::mem_wb_t  mem_wb,
    input  tinker_pkg::reg_idx_t dec_rs,
    input  tinker_pkg::reg_idx_t dec_rt,
    input  tinker_pkg::reg_idx_t dec_rd,
    input  tinker_pkg::ctrl_t    dec_ctrl,
    output tinker_pkg::fwd_sel_t sel_rs,
    output tinker_pkg::fwd_sel_t sel_rt,
    output tinker_pkg::fwd_sel_t sel_rd,
    output logic                 load_stall
);

    logic uses_rt;
    logic uses_rd;

    // Youngest producer wins, loads never forward from EX/MEM
    function automatic tinker_pkg::fwd_sel_t src_of(tinker_pkg::reg_idx_t idx);
        if (ex_mem.valid && ex_mem.ctrl.reg_write && !ex_mem.ctrl.is_load && ex_mem.rd == idx)
            return tinker_pkg::fwd_exm;
        if (mem_wb.valid && mem_wb.reg_write && mem_wb.rd == idx)
            return tinker_pkg::fwd_wb;
        return tinker_pkg::fwd_rf;
    endfunction

    always_comb begin
        sel_rs = src_of(id_ex.rs);
        sel_rt = src_of(id_ex.rt);
        sel_rd = src_of(id_ex.rd);
    end

    assign uses_rt = !dec_ctrl.use_imm;                      // Conservative for not/movr
    assign uses_rd = dec_ctrl.is_store | dec_ctrl.is_branch;

    assign load_stall = id_ex.valid && id_ex.ctrl.is_load &&
                        (id_ex.rd == dec_rs ||
                         (uses_rt && id_ex.rd == dec_rt) ||
                         (uses_rd && id_ex.rd == dec_rd));

endmodule

// File: design/execute_unit.sv
//----------------------------------------------------------
// Execute stage: ALU, branch resolution and target,
// load/store address generation. Purely combinational.
//----------------------------------------------------------
`timescale 1ns/1ps

module execute_unit (
    input  tinker_pkg::id_ex_t  id_ex,
    input  tinker_pkg::word_t   op_rs,
    input  tinker_pkg::word_t   op_rt,
    input  tinker_pkg::word_t   op_rd,
    output tinker_pkg::ex_mem_t ex_out,
    output logic                redirect,
    output tinker_pkg::word_t   target
);

    tinker_pkg::word_t op_b;     // rt or the literal
    tinker_pkg::word_t result;
    logic              taken;

    assign op_b = id_ex.ctrl.use_imm ? id_ex.imm : op_rt;

    always_comb begin
        result = '0;
        taken  = 1'b0;
        target = op_rd;                                  // Absolute forms go to rd
        case (id_ex.ctrl.op)
            tinker_pkg::op_and:    result = op_rs & op_b;
            tinker_pkg::op_or:     result = op_rs | op_b;
            tinker_pkg::op_xor:    result = op_rs ^ op_b;
            tinker_pkg::op_not:    result = ~op_rs;
            tinker_pkg::op_shftr,
            tinker_pkg::op_shftri: result = op_rs >> op_b[5:0];
            tinker_pkg::op_shftl,
            tinker_pkg::op_shftli: result = op_rs << op_b[5:0];
            tinker_pkg::op_add,
            tinker_pkg::op_addi:   result = op_rs + op_b;
            tinker_pkg::op_sub,
            tinker_pkg::op_subi:   result = op_rs - op_b;
            tinker_pkg::op_movr:   result = op_rs;
            tinker_pkg::op_movl:   result = id_ex.imm;
            tinker_pkg::op_br:     taken = 1'b1;
            tinker_pkg::op_brr: begin
                taken  = 1'b1;
                target = id_ex.pc + op_rd;
            end
            tinker_pkg::op_brrl: begin
                taken  = 1'b1;
                target = id_ex.pc + id_ex.imm;
            end
            tinker_pkg::op_brnz:   taken = (op_rs != '0);
            tinker_pkg::op_brgt:   taken = ($signed(op_rs) > $signed(op_rt));
            default: ;
        endcase
    end

    assign redirect = id_ex.valid && taken;

    //----------------------------------------------------------
    // Result packet for the memory stage
    //----------------------------------------------------------
    always_comb begin
        ex_out            = '0;
        ex_out.valid      = id_ex.valid;
        ex_out.ctrl       = id_ex.ctrl;
        ex_out.rd         = id_ex.rd;
        ex_out.result     = result;
        ex_out.store_data = op_rs;
        // Store addresses off rd, load off rs
        ex_out.addr       = id_ex.ctrl.is_store ? op_rd + id_ex.imm : op_rs + id_ex.imm;
    end

endmodule

// File: design/tinker_core.sv
//----------------------------------------------------------
// Five-stage Tinker core top level. Instruction and data
// memories live outside, reached through the imem/dmem ports.
// hlt rises when a halt reaches writeback and stays high.
//----------------------------------------------------------
`timescale 1ns/1ps

module tinker_core (
    input  logic                  clk,
    input  logic                  reset,
    output tinker_pkg::word_t     imem_addr,
    input  tinker_pkg::inst_t     imem_data,
    output tinker_pkg::dmem_req_t dmem_req,
    input  tinker_pkg::word_t     dmem_rdata,
    output logic                  hlt
);

    tinker_pkg::word_t    ifid_pc;
    tinker_pkg::inst_t    ifid_inst;
    logic                 ifid_valid;
    tinker_pkg::ctrl_t    dec_ctrl;
    tinker_pkg::reg_idx_t dec_rd, dec_rs, dec_rt;
    tinker_pkg::word_t    dec_imm;
    tinker_pkg::word_t    rf_rd, rf_rs, rf_rt;
    tinker_pkg::id_ex_t   id_ex_d, id_ex_q;
    tinker_pkg::ex_mem_t  ex_mem_d, ex_mem_q;
    tinker_pkg::mem_wb_t  mem_wb_d, mem_wb_q;
    tinker_pkg::fwd_sel_t sel_rs, sel_rt, sel_rd;
    tinker_pkg::word_t    op_rs, op_rt, op_rd;
    tinker_pkg::word_t    target;
    logic                 redirect, load_stall, stall, freeze, hlt_q;

    function automatic tinker_pkg::word_t pick(tinker_pkg::fwd_sel_t sel,
                                               tinker_pkg::word_t rf,
                                               tinker_pkg::word_t exm,
                                               tinker_pkg::word_t wb);
        case (sel)
            tinker_pkg::fwd_exm: return exm;
            tinker_pkg::fwd_wb:  return wb;
            default:             return rf;
        endcase
    endfunction

    assign stall  = load_stall & ifid_valid;
    assign freeze = id_ex_q.valid & id_ex_q.ctrl.is_halt;   // Halt now in execute

    fetch_stage u_fetch (
        .clk, .reset, .redirect, .target, .stall, .freeze, .imem_data,
        .imem_addr, .ifid_pc, .ifid_inst, .ifid_valid
    );

    //----------------------------------------------------------
    // Decode
    //----------------------------------------------------------
    instr_decoder u_dec (
        .inst(ifid_inst), .ctrl(dec_ctrl), .rd(dec_rd), .rs(dec_rs), .rt(dec_rt), .imm(dec_imm)
    );

    register_file u_rf (
        .clk, .reset,
        .rd_idx(dec_rd), .rs_idx(dec_rs), .rt_idx(dec_rt),
        .wr_en(mem_wb_q.valid & mem_wb_q.reg_write), .wr_idx(mem_wb_q.rd),
        .wr_data(mem_wb_q.wb_data),
        .rd_val(rf_rd), .rs_val(rf_rs), .rt_val(rf_rt)
    );

    assign id_ex_d = '{valid: ifid_valid, pc: ifid_pc, ctrl: dec_ctrl,
                       rd: dec_rd, rs: dec_rs, rt: dec_rt, imm: dec_imm,
                       rd_val: rf_rd, rs_val: rf_rs, rt_val: rf_rt};

    pipe_reg #(.payload_t(tinker_pkg::id_ex_t)) u_id_ex (
        .clk, .reset, .hold(1'b0), .flush(redirect | stall | freeze), .d(id_ex_d), .q(id_ex_q)
    );

    //----------------------------------------------------------
    // Execute with forwarded operands
    //----------------------------------------------------------
    hazard_unit u_haz (
        .id_ex(id_ex_q), .ex_mem(ex_mem_q), .mem_wb(mem_wb_q),
        .dec_rs, .dec_rt, .dec_rd, .dec_ctrl,
        .sel_rs, .sel_rt, .sel_rd, .load_stall
    );

    assign op_rs = pick(sel_rs, id_ex_q.rs_val, ex_mem_q.result, mem_wb_q.wb_data);
    assign op_rt = pick(sel_rt, id_ex_q.rt_val, ex_mem_q.result, mem_wb_q.wb_data);
    assign op_rd = pick(sel_rd, id_ex_q.rd_val, ex_mem_q.result, mem_wb_q.wb_data);

    execute_unit u_ex (
        .id_ex(id_ex_q), .op_rs, .op_rt, .op_rd, .ex_out(ex_mem_d), .redirect, .target
    );

    pipe_reg #(.payload_t(tinker_pkg::ex_mem_t)) u_ex_mem (
        .clk, .reset, .hold(1'b0), .flush(1'b0), .d(ex_mem_d), .q(ex_mem_q)
    );

    //----------------------------------------------------------
    // Memory stage and writeback
    //----------------------------------------------------------
    assign dmem_req = '{wr_valid: ex_mem_q.valid & ex_mem_q.ctrl.is_store,
                        wr_addr: ex_mem_q.addr, wr_data: ex_mem_q.store_data,
                        rd_addr: ex_mem_q.addr};

    assign mem_wb_d = '{valid: ex_mem_q.valid, rd: ex_mem_q.rd,
                        wb_data: ex_mem_q.ctrl.is_load ? dmem_rdata : ex_mem_q.result,
                        reg_write: ex_mem_q.ctrl.reg_write, halt: ex_mem_q.ctrl.is_halt};

    pipe_reg #(.payload_t(tinker_pkg::mem_wb_t)) u_mem_wb (
        .clk, .reset, .hold(1'b0), .flush(1'b0), .d(mem_wb_d), .q(mem_wb_q)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hlt_q <= 1'b0;
        end else if (mem_wb_q.valid && mem_wb_q.halt) begin
            hlt_q <= 1'b1;
        end
    end

    assign hlt = hlt_q | (mem_wb_q.valid & mem_wb_q.halt);

endmodule

// File: include/tinker_model.svh
//----------------------------------------------------------
// Instruction-set reference model and random program maker,
// included inside the testbench module. gen() builds a program
// for reset_pc, run() executes it in order and records every
// store in st_addr/st_data.
//----------------------------------------------------------
`ifndef TINKER_MODEL_SVH
`define TINKER_MODEL_SVH

    tinker_pkg::inst_t prog[$];
    tinker_pkg::word_t st_addr[$];
    tinker_pkg::word_t st_data[$];
    integer            seed;

    function automatic int rnd(int m);
        return int'($unsigned($random(seed)) % m);
    endfunction

    function automatic tinker_pkg::reg_idx_t rreg();
        return tinker_pkg::reg_idx_t'(1 + rnd(13));     // r1..r13, r14/r15 reserved
    endfunction

    function automatic void emit(tinker_pkg::opcode_t op, tinker_pkg::reg_idx_t rd,
                                 tinker_pkg::reg_idx_t rs, tinker_pkg::reg_idx_t rt,
                                 logic [11:0] imm);
        prog.push_back({op, rd, rs, rt, imm});
    endfunction

    function automatic void emit_random();
        tinker_pkg::opcode_t ops[16] = '{
            tinker_pkg::op_and, tinker_pkg::op_or, tinker_pkg::op_xor, tinker_pkg::op_not,
            tinker_pkg::op_shftr, tinker_pkg::op_shftri, tinker_pkg::op_shftl,
            tinker_pkg::op_shftli, tinker_pkg::op_add, tinker_pkg::op_addi,
            tinker_pkg::op_sub, tinker_pkg::op_subi, tinker_pkg::op_movr,
            tinker_pkg::op_movl, tinker_pkg::op_load, tinker_pkg::op_store};
        tinker_pkg::opcode_t op;
        op = (rnd(4) == 0) ? tinker_pkg::op_store : ops[rnd(16)];
        case (op)
            tinker_pkg::op_load:  emit(op, rreg(), 5'd14, 5'd0, 12'(8 * rnd(32)));
            tinker_pkg::op_store: emit(op, 5'd14, rreg(), 5'd0, 12'(8 * rnd(32)));
            default:              emit(op, rreg(), rreg(), rreg(), 12'(rnd(4096)));
        endcase
    endfunction

    // Forward branch over k random instructions
    function automatic void emit_branch();
        int          k;
        int          kind;
        logic [11:0] rel;
        k    = 1 + rnd(3);
        kind = rnd(5);
        rel  = 12'(4 * (k + 1));
        if (kind == 0 || kind >= 3) begin
            emit(tinker_pkg::op_movl, 5'd15, 5'd0, 5'd0, 12'h200);
            emit(tinker_pkg::op_shftli, 5'd15, 5'd15, 5'd0, 12'd4);
            // Branch follows this addi, then k skipped words
            emit(tinker_pkg::op_addi, 5'd15, 5'd15, 5'd0, 12'(4 * (prog.size() + 2 + k)));
        end
        case (kind)
            0: emit(tinker_pkg::op_br, 5'd15, 5'd0, 5'd0, 12'd0);
            1: begin
                emit(tinker_pkg::op_movl, 5'd15, 5'd0, 5'd0, rel);
                emit(tinker_pkg::op_brr, 5'd15, 5'd0, 5'd0, 12'd0);
            end
            2: emit(tinker_pkg::op_brrl, 5'd0, 5'd0, 5'd0, rel);
            3: emit(tinker_pkg::op_brnz, 5'd15, rreg(), 5'd0, 12'd0);
            default: emit(tinker_pkg::op_brgt, 5'd15, rreg(), rreg(), 12'd0);
        endcase
        repeat (k) emit_random();
    endfunction

    function automatic void gen(int n);
        prog.delete();
        emit(tinker_pkg::op_movl, 5'd14, 5'd0, 5'd0, 12'h100);    // Data window at 0x1000
        emit(tinker_pkg::op_shftli, 5'd14, 5'd14, 5'd0, 12'd4);
        repeat (n) begin
            if (rnd(6) == 0) emit_branch();
            else emit_random();
        end
        emit(tinker_pkg::op_halt, 5'd0, 5'd0, 5'd0, 12'd0);
    endfunction

    function automatic void run();
        tinker_pkg::word_t    r [32];
        tinker_pkg::word_t    mem [tinker_pkg::word_t];
        tinker_pkg::word_t    pc;
        tinker_pkg::word_t    npc;
        tinker_pkg::word_t    a;
        tinker_pkg::word_t    b;
        tinker_pkg::word_t    d;
        tinker_pkg::word_t    imm;
        tinker_pkg::inst_t    iw;
        tinker_pkg::reg_idx_t rd;
        st_addr.delete();
        st_data.delete();
        foreach (r[i]) r[i] = '0;
        pc = tinker_pkg::reset_pc;
        repeat (4096) begin
            if (((pc - tinker_pkg::reset_pc) >> 2) >= prog.size()) return;
            iw  = prog[(pc - tinker_pkg::reset_pc) >> 2];
            rd  = iw[26:22];
            a   = r[iw[21:17]];
            b   = r[iw[16:12]];
            d   = r[rd];
            imm = {{52{iw[11]}}, iw[11:0]};
            npc = pc + 64'd4;
            case (tinker_pkg::opcode_t'(iw[31:27]))
                tinker_pkg::op_and:    r[rd] = a & b;
                tinker_pkg::op_or:     r[rd] = a | b;
                tinker_pkg::op_xor:    r[rd] = a ^ b;
                tinker_pkg::op_not:    r[rd] = ~a;
                tinker_pkg::op_shftr:  r[rd] = a >> b[5:0];
                tinker_pkg::op_shftri: r[rd] = a >> imm[5:0];
                tinker_pkg::op_shftl:  r[rd] = a << b[5:0];
                tinker_pkg::op_shftli: r[rd] = a << imm[5:0];
                tinker_pkg::op_add:    r[rd] = a + b;
                tinker_pkg::op_addi:   r[rd] = a + imm;
                tinker_pkg::op_sub:    r[rd] = a - b;
                tinker_pkg::op_subi:   r[rd] = a - imm;
                tinker_pkg::op_movr:   r[rd] = a;
                tinker_pkg::op_movl:   r[rd] = imm;
                tinker_pkg::op_load:   r[rd] = mem.exists(a + imm) ? mem[a + imm] : '0;
                tinker_pkg::op_store: begin
                    mem[d + imm] = a;
                    st_addr.push_back(d + imm);
                    st_data.push_back(a);
                end
                tinker_pkg::op_br:     npc = d;
                tinker_pkg::op_brr:    npc = pc + d;
                tinker_pkg::op_brrl:   npc = pc + imm;
                tinker_pkg::op_brnz:   npc = (a != '0) ? d : npc;
                tinker_pkg::op_brgt:   npc = ($signed(a) > $signed(b)) ? d : npc;
                tinker_pkg::op_halt:   return;
                default: ;
            endcase
            pc = npc;
        end
    endfunction

`endif

// File: tb/tinker_tb.sv
//----------------------------------------------------------
// Testbench for the Tinker core. Builds random programs with
// the reference model, serves both memory ports and checks
// each store in order, the store count and the halt.
//----------------------------------------------------------
`timescale 1ns/1ps

module tinker_tb;

    localparam int num_programs = 8;
    localparam int imem_depth   = 1024;
    localparam int dmem_words   = 32;       // 256-byte data window
    localparam int halt_timeout = 5000;
    localparam int quiet_cycles = 20;
    localparam tinker_pkg::word_t dmem_base = 64'h1000;
    localparam tinker_pkg::inst_t nop_inst  = 32'hf800_0000;   // Opcode 0x1f, undefined

    logic                  clk;
    logic                  reset;
    tinker_pkg::word_t     imem_addr;
    tinker_pkg::inst_t     imem_data;
    tinker_pkg::dmem_req_t dmem_req;
    tinker_pkg::word_t     dmem_rdata;
    logic                  hlt;

    tinker_pkg::inst_t imem [imem_depth];
    tinker_pkg::word_t dmem [dmem_words];
    tinker_pkg::word_t imem_off;
    int                store_count;

`include "tinker_model.svh"

    tinker_core uut (
        .clk, .reset, .imem_addr, .imem_data, .dmem_req, .dmem_rdata, .hlt
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //----------------------------------------------------------
    // Memory model
    //----------------------------------------------------------
    function automatic logic in_window(tinker_pkg::word_t addr);
        return addr >= dmem_base && addr < dmem_base + 64'(8 * dmem_words) &&
               addr[2:0] == 3'b000;
    endfunction

    function automatic logic [4:0] word_index(tinker_pkg::word_t addr);
        tinker_pkg::word_t off;
        off = (addr - dmem_base) >> 3;
        return off[4:0];
    endfunction

    assign imem_off  = (imem_addr - tinker_pkg::reset_pc) >> 2;
    assign imem_data = (imem_addr >= tinker_pkg::reset_pc && imem_off < 64'(imem_depth)) ?
                       imem[imem_off[9:0]] : nop_inst;

    // Outside the window reads return zero, like the model
    assign dmem_rdata = in_window(dmem_req.rd_addr) ? dmem[word_index(dmem_req.rd_addr)] : '0;

    always @(posedge clk) begin
        if (reset) begin
            foreach (dmem[i]) dmem[i] <= '0;
        end else if (dmem_req.wr_valid && in_window(dmem_req.wr_addr)) begin
            dmem[word_index(dmem_req.wr_addr)] <= dmem_req.wr_data;
        end
    end

    //----------------------------------------------------------
    // Checking
    //----------------------------------------------------------
    task automatic stop_on_failure();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check(input tinker_pkg::word_t got, input tinker_pkg::word_t expected,
                         input string what);
        if (got !== expected) begin
            $display("mismatch at time %0t: %s, got %h, expected %h", $time, what, got, expected);
            stop_on_failure();
        end
    endtask

    // Compares a store seen this cycle with the next one the model made
    task automatic observe_store();
        if (dmem_req.wr_valid) begin
            if (store_count >= st_addr.size()) begin
                $display("Unexpected extra store at time %0t to address %h",
                         $time, dmem_req.wr_addr);
                stop_on_failure();
            end else begin
                check(dmem_req.wr_addr, st_addr[store_count],
                      $sformatf("store %0d address", store_count));
                check(dmem_req.wr_data, st_data[store_count],
                      $sformatf("store %0d data", store_count));
                store_count++;
            end
        end
    endtask

    task automatic load_program(int n);
        gen(n);
        run();
        if (prog.size() > imem_depth) begin
            $display("Program of %0d words does not fit the instruction memory",
                     prog.size());
            stop_on_failure();
        end
        foreach (imem[i]) begin
            imem[i] = (i < prog.size()) ? prog[i] : nop_inst;
        end
        store_count = 0;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (2) begin
            @(negedge clk);
            check(imem_addr, tinker_pkg::reset_pc, "imem_addr during reset");
            check(64'(hlt), 64'd0, "hlt during reset");
            check(64'(dmem_req.wr_valid), 64'd0, "store strobe during reset");
        end
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check(imem_addr, tinker_pkg::reset_pc, "imem_addr after reset");
        check(64'(hlt), 64'd0, "hlt after reset");
    endtask

    task automatic wait_for_halt(int prog_num);
        int   cycles;
        logic done;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(negedge clk);
            observe_store();
            cycles++;
            if (hlt) begin
                done = 1'b1;
            end else if (cycles >= halt_timeout) begin
                $display("Timeout: program %0d did not halt within %0d cycles",
                         prog_num, halt_timeout);
                stop_on_failure();
            end
        end
        check(64'(store_count), 64'(st_addr.size()),
              $sformatf("store count of program %0d", prog_num));
    endtask

    // Core must stay halted and silent
    task automatic check_halt_holds();
        repeat (quiet_cycles) begin
            @(negedge clk);
            check(64'(hlt), 64'd1, "hlt after halt");
            check(64'(dmem_req.wr_valid), 64'd0, "store strobe after halt");
        end
    endtask

    //----------------------------------------------------------
    // Main sequence
    //----------------------------------------------------------
    initial begin
        reset       = 1'b1;
        store_count = 0;
        seed        = 32'h79008c36;
        for (int p = 0; p < num_programs; p++) begin
            load_program(30 + rnd(30));
            $display("Program %0d: %0d instructions, %0d stores expected",
                     p, prog.size(), st_addr.size());
            apply_reset();
            wait_for_halt(p);
            check_halt_holds();
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: all.f
+incdir+include
design/tinker_pkg.sv
design/pipe_reg.sv
design/fetch_stage.sv
design/instr_decoder.sv
design/register_file.sv
design/hazard_unit.sv
design/execute_unit.sv
design/tinker_core.sv
tb/tinker_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from sim.log
rm -rf obj_dir sim.log build.log
verilator --binary --timing -Wno-fatal --top-module tinker_tb -f all.f -o tinker_sim \
    > build.log 2>&1 || { cat build.log; echo "FAIL"; exit 1; }
./obj_dir/tinker_sim > sim.log 2>&1
cat sim.log
grep -q "All tests passed!" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
